// ==== hdl/smu_ctrl_pkg.sv ====
/*
  Shared widths, register map and preset tables for the SMU control FPGA.
  Modules refer to these by scoped name; the slot order here fixes the
  meaning of every nibble in the register bank.
*/

package smu_ctrl_pkg;

  //////////////////////////////
  // widths

  // one control register
  localparam int NIBBLE_W = 4;

  // default bank size, the top level passes its own copy down
  localparam int NUM_REGS = 8;

  // address byte then value byte, msb first
  localparam int FRAME_W = 16;

  typedef logic [NIBBLE_W-1:0] ctrl_nibble_t;

  // bank of register outputs, slot 0 in the low nibble
  typedef logic [NUM_REGS-1:0][NIBBLE_W-1:0] ctrl_bank_t;

  typedef logic [7:0] spi_byte_t;

  //////////////////////////////
  // address map

  // slot i answers at REG_BASE + i
  localparam spi_byte_t REG_BASE = 8'd16;

  // rail monitor inputs, read only
  localparam spi_byte_t ADDR_MON_RAILS = 8'd24;

  // whole bank commands, the value byte is ignored
  localparam spi_byte_t ADDR_SOFT_RESET = 8'd11;
  localparam spi_byte_t ADDR_RAILS_UP = 8'd6;

  //////////////////////////////
  // presets
  //
  // slot order, high to low:
  // rails_oe mux_sel mux_pol dac_ref_mux rails dac_ctl periph_sel led

  // power-on state, analog switches and rail enables are active low
  localparam ctrl_bank_t SOFT_RESET_VAL = {
    4'b1111,
    4'b1111,
    4'b1111,
    4'b0000,
    4'b0000,
    4'b0000,
    4'b0000,
    4'b0000
  };

  // rails on, switches still off
  // dac_ctl and periph_sel entries are never loaded, see keep mask
  localparam ctrl_bank_t RAILS_UP_VAL = {
    4'b0000,
    4'b1111,
    4'b1111,
    4'b0011,
    4'b0011,
    4'b0000,
    4'b0000,
    4'b0000
  };

  // dac already set up before the rails come up, leave it alone
  localparam logic [NUM_REGS-1:0] RAILS_UP_KEEP = 8'b0000_0110;

  // shifted out while the address byte is still coming in
  localparam spi_byte_t READ_IDLE_BYTE = 8'hFF;

  // slot feeding the peripheral chip select decode
  localparam int SLOT_PERIPH_SEL = 1;

endpackage

// ==== hdl/reg_bus_if.sv ====
/*
  Register bus between the SPI frame receiver, the control slots and
  the readback selector. One broadcast write group, one read group.
*/

interface reg_bus_if (
  input logic clk
);

  // broadcast write, addr and val valid while commit is high
  logic                       commit;
  smu_ctrl_pkg::spi_byte_t    addr;
  smu_ctrl_pkg::spi_byte_t    val;

  // read path, answered combinationally
  smu_ctrl_pkg::spi_byte_t    rd_addr;
  smu_ctrl_pkg::ctrl_nibble_t rd_data;

  // frame receiver side
  modport rx (
    input  clk,
    output commit,
    output addr,
    output val,
    output rd_addr,
    input  rd_data
  );

  // every slot listens, each one matches its own address
  modport slot (
    input clk,
    input commit,
    input addr,
    input val
  );

  modport readback (
    input  rd_addr,
    output rd_data
  );

endinterface

// ==== hdl/spi_frame_rx.sv ====
/*
  SPI slave for 16-bit register frames, pins oversampled in the clk domain.
  Needs at least 3 clk cycles per sck half period. A frame of exactly
  FRAME_W bits commits 3 cycles after cs_n is first seen high.
*/

module spi_frame_rx (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        sck,
  input  logic        cs_n,
  input  logic        mosi,
  output logic        sdo,
  reg_bus_if.rx       bus
);

  localparam int BYTE_W = $bits(smu_ctrl_pkg::spi_byte_t);
  localparam int CNT_W = $clog2(smu_ctrl_pkg::FRAME_W) + 1;

  // two sync flops, third stage is edge history
  logic [2:0] sck_q;
  logic [2:0] cs_n_q;
  logic [1:0] mosi_q;

  logic in_frame;
  logic sck_rise;
  logic sck_fall;
  logic cs_rise;

  logic [CNT_W-1:0] bit_cnt;
  logic [smu_ctrl_pkg::FRAME_W-1:0] rx_shift;
  smu_ctrl_pkg::spi_byte_t tx_shift;
  logic frame_ok;

  //////////////////////////////
  // pin sync and edges

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sck_q  <= '0;
      cs_n_q <= '1;
      mosi_q <= '0;
    end
    else
    begin
      sck_q  <= {sck_q[1:0], sck};
      cs_n_q <= {cs_n_q[1:0], cs_n};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  assign in_frame = ~cs_n_q[1];
  // sck edges only count inside a frame
  assign sck_rise = in_frame & sck_q[1] & ~sck_q[2];
  assign sck_fall = in_frame & ~sck_q[1] & sck_q[2];
  assign cs_rise  = cs_n_q[1] & ~cs_n_q[2];

  //////////////////////////////
  // bit count and transmit side

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt  <= '0;
      tx_shift <= smu_ctrl_pkg::READ_IDLE_BYTE;
    end
    else if (!in_frame)
    begin
      // idle, ready for the next frame
      bit_cnt  <= '0;
      tx_shift <= smu_ctrl_pkg::READ_IDLE_BYTE;
    end
    else
    begin
      // saturate so long frames never wrap back to FRAME_W
      if (sck_rise && bit_cnt != '1)
        bit_cnt <= bit_cnt + 1'b1;
      if (sck_fall)
      begin
        // address byte done, rd_addr already latched
        if (bit_cnt == CNT_W'(BYTE_W))
          tx_shift <= {{(BYTE_W - smu_ctrl_pkg::NIBBLE_W){1'b0}}, bus.rd_data};
        else
          tx_shift <= {tx_shift[BYTE_W-2:0], 1'b0};
      end
    end
  end

  assign sdo = tx_shift[BYTE_W-1];

  // read address, taken with the eighth bit
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      bus.rd_addr <= '0;
    else if (sck_rise && bit_cnt == CNT_W'(BYTE_W - 1))
      bus.rd_addr <= {rx_shift[BYTE_W-2:0], mosi_q[1]};
  end

  //////////////////////////////
  // receive shifter and commit

  always_ff @(posedge clk)
  begin
    if (sck_rise)
      rx_shift <= {rx_shift[smu_ctrl_pkg::FRAME_W-2:0], mosi_q[1]};
    if (frame_ok)
    begin
      bus.addr <= rx_shift[smu_ctrl_pkg::FRAME_W-1:BYTE_W];
      bus.val  <= rx_shift[BYTE_W-1:0];
    end
  end

  // length check on cs_n rise, commit one cycle later with the payload
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      frame_ok   <= 1'b0;
      bus.commit <= 1'b0;
    end
    else
    begin
      frame_ok   <= cs_rise && (bit_cnt == CNT_W'(smu_ctrl_pkg::FRAME_W));
      bus.commit <= frame_ok;
    end
  end

endmodule

// ==== hdl/ctrl_reg_slot.sv ====
/*
  One 4-bit control register on the broadcast bus. Writes use the
  set/clear/toggle encoding, the two command addresses load presets.
*/

module ctrl_reg_slot #(
  parameter smu_ctrl_pkg::spi_byte_t    ADDR         = smu_ctrl_pkg::REG_BASE,
  parameter smu_ctrl_pkg::ctrl_nibble_t RESET_VAL    = '0,
  parameter smu_ctrl_pkg::ctrl_nibble_t RAILS_UP_VAL = '0,
  parameter bit                         KEEP         = 1'b0
) (
  input  logic                       clk,
  input  logic                       arst_n,
  reg_bus_if.slot                    bus,
  output smu_ctrl_pkg::ctrl_nibble_t value
);

  localparam int NW = smu_ctrl_pkg::NIBBLE_W;

  smu_ctrl_pkg::ctrl_nibble_t set_bits;
  smu_ctrl_pkg::ctrl_nibble_t clr_bits;
  smu_ctrl_pkg::ctrl_nibble_t overlap;
  smu_ctrl_pkg::ctrl_nibble_t upd_val;

  // value byte: set nibble low, clear nibble high
  assign set_bits = bus.val[NW-1:0];
  assign clr_bits = bus.val[2*NW-1:NW];
  assign overlap  = set_bits & clr_bits;

  always_comb
  begin
    // both set and clear on a bit means toggle it
    if (overlap != '0)
      upd_val = value ^ overlap;
    else
      upd_val = (value | set_bits) & ~clr_bits;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      value <= RESET_VAL;
    else if (bus.commit)
    begin
      if (bus.addr == ADDR)
        value <= upd_val;
      else if (bus.addr == smu_ctrl_pkg::ADDR_SOFT_RESET)
        value <= RESET_VAL;
      // kept slots ride through rails-up untouched
      else if (bus.addr == smu_ctrl_pkg::ADDR_RAILS_UP && !KEEP)
        value <= RAILS_UP_VAL;
    end
  end

endmodule

// ==== hdl/readback_sel.sv ====
/*
  Read mux for the frame receiver. Answers slot addresses with the slot
  value and the monitor address with the rail inputs, zero elsewhere.
*/

module readback_sel #(
  parameter int NUM_REGS = smu_ctrl_pkg::NUM_REGS
) (
  input  smu_ctrl_pkg::ctrl_bank_t   regs,
  input  smu_ctrl_pkg::ctrl_nibble_t mon_rails,
  reg_bus_if.readback                bus
);

  //////////////////////////////
  // address decode

  // purely combinational, the receiver loads the result
  // on the sck fall after the address byte
  always_comb
  begin
    // unused addresses read as zero
    bus.rd_data = '0;

    if (bus.rd_addr == smu_ctrl_pkg::ADDR_MON_RAILS)
      bus.rd_data = mon_rails;

    // slot window REG_BASE .. REG_BASE + NUM_REGS - 1
    for (int i = 0; i < NUM_REGS; i++)
    begin
      if (bus.rd_addr == smu_ctrl_pkg::spi_byte_t'(smu_ctrl_pkg::REG_BASE + i))
        bus.rd_data = regs[i];
    end
  end

endmodule

// ==== hdl/periph_spi_mux.sv ====
/*
  Peripheral SPI pass-through on the second chip select.
  periph_sel picks which devices see cs2_n and which MISO lines return.
*/

module periph_spi_mux (
  input  logic                       cs2_n,
  input  smu_ctrl_pkg::ctrl_nibble_t periph_sel,
  input  logic                       sdo,
  input  smu_ctrl_pkg::ctrl_nibble_t periph_miso,
  output smu_ctrl_pkg::ctrl_nibble_t periph_cs_n,
  output logic                       miso
);

  logic sel_miso;

  //////////////////////////////
  // chip selects

  // cs2_n high, nothing selected
  // low, every device with its periph_sel bit set is pulled low
  assign periph_cs_n = cs2_n ? '1 : ~periph_sel;

  //////////////////////////////
  // miso return

  // unselected devices may float, so mask before the or
  assign sel_miso = |(periph_sel & periph_miso);

  // register bank drives miso whenever cs2_n is idle
  assign miso = cs2_n ? sdo : sel_miso;

endmodule

// ==== hdl/smu_ctrl_top.sv ====
/*
  Top level of the SMU control FPGA. SPI frames on cs_n write and read
  the control bank, cs2_n passes the host through to the peripherals.
*/

module smu_ctrl_top #(
  parameter int NUM_REGS = smu_ctrl_pkg::NUM_REGS
) (
  input  logic                       clk,
  input  logic                       arst_n,
  // host spi
  input  logic                       sck,
  input  logic                       cs_n,
  input  logic                       mosi,
  input  logic                       cs2_n,
  output logic                       miso,
  // rail monitor comparators
  input  smu_ctrl_pkg::ctrl_nibble_t mon_rails,
  // peripheral spi devices
  input  smu_ctrl_pkg::ctrl_nibble_t periph_miso,
  output smu_ctrl_pkg::ctrl_nibble_t periph_cs_n,
  // control register outputs
  output smu_ctrl_pkg::ctrl_bank_t   reg_out
);

  // register bank serial out, before the pass-through mux
  logic sdo;

  reg_bus_if u_bus (
    .clk (clk)
  );

  //////////////////////////////
  // frame receiver

  spi_frame_rx u_rx (
    .clk    (clk),
    .arst_n (arst_n),
    .sck    (sck),
    .cs_n   (cs_n),
    .mosi   (mosi),
    .sdo    (sdo),
    .bus    (u_bus)
  );

  //////////////////////////////
  // control slots

  // address and presets per slot from the package tables
  for (genvar i = 0; i < NUM_REGS; i++)
  begin : g_slot
    ctrl_reg_slot #(
      .ADDR         (smu_ctrl_pkg::spi_byte_t'(smu_ctrl_pkg::REG_BASE + i)),
      .RESET_VAL    (smu_ctrl_pkg::SOFT_RESET_VAL[i]),
      .RAILS_UP_VAL (smu_ctrl_pkg::RAILS_UP_VAL[i]),
      .KEEP         (smu_ctrl_pkg::RAILS_UP_KEEP[i])
    ) u_slot (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (u_bus),
      .value  (reg_out[i])
    );
  end

  //////////////////////////////
  // readback and pass-through

  readback_sel #(
    .NUM_REGS (NUM_REGS)
  ) u_readback (
    .regs      (reg_out),
    .mon_rails (mon_rails),
    .bus       (u_bus)
  );

  periph_spi_mux u_periph (
    .cs2_n       (cs2_n),
    .periph_sel  (reg_out[smu_ctrl_pkg::SLOT_PERIPH_SEL]),
    .sdo         (sdo),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

endmodule

// ==== test/smu_ctrl_assert.sv ====
/*
  Concurrent checks for the SMU control top level, attached to every
  instance of it by the bind at the end of this file.
*/

module smu_ctrl_assert (
  input logic                       clk,
  input logic                       arst_n,
  input logic                       cs_n,
  input logic                       cs2_n,
  input smu_ctrl_pkg::ctrl_nibble_t periph_cs_n,
  input smu_ctrl_pkg::ctrl_bank_t   reg_out
);

  // read by the testbench at the end of the run
  int fail_cnt = 0;

  // no peripheral selected while the pass-through is idle
  a_periph_idle: assert property (@(posedge clk) disable iff (!arst_n)
    cs2_n |-> periph_cs_n == '1)
    else
    begin
      $error("periph_cs_n not all ones with cs2_n high");
      fail_cnt++;
    end

  // commit only follows the end of a frame
  a_bank_stable: assert property (@(posedge clk) disable iff (!arst_n)
    !cs_n |-> $stable(reg_out))
    else
    begin
      $error("reg_out changed while cs_n low");
      fail_cnt++;
    end

  a_reset_val: assert property (@(posedge clk)
    $rose(arst_n) |-> reg_out == smu_ctrl_pkg::SOFT_RESET_VAL)
    else
    begin
      $error("reg_out not at power-on values after reset");
      fail_cnt++;
    end

endmodule

bind smu_ctrl_top smu_ctrl_assert u_assert (
  .clk         (clk),
  .arst_n      (arst_n),
  .cs_n        (cs_n),
  .cs2_n       (cs2_n),
  .periph_cs_n (periph_cs_n),
  .reg_out     (reg_out)
);

// ==== test/smu_ctrl_tb.sv ====
/*
  Directed testbench for the SMU control top level. Sends SPI frames on
  cs_n, drives cs2_n for the peripheral path, checks bank and readback.
*/

module smu_ctrl_tb;

  localparam int NUM_REGS = smu_ctrl_pkg::NUM_REGS;
  // all tests together send fewer frames than this
  localparam int NUM_FRAMES = 50;
  // one frame is about 140 clk cycles including the gap
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * 160 + 500;

  logic clk = 1'b0;
  logic arst_n;
  logic sck;
  logic cs_n;
  logic mosi;
  logic cs2_n;
  logic miso;
  smu_ctrl_pkg::ctrl_nibble_t mon_rails;
  smu_ctrl_pkg::ctrl_nibble_t periph_miso;
  smu_ctrl_pkg::ctrl_nibble_t periph_cs_n;
  smu_ctrl_pkg::ctrl_bank_t reg_out;

  // expected bank, follows every write sent
  smu_ctrl_pkg::ctrl_bank_t exp_bank;
  integer seed = 95;
  int err_cnt = 0;
  int last_err = 0;
  int test_cnt = 0;

  smu_ctrl_top #(
    .NUM_REGS (NUM_REGS)
  ) DUT (.*);

  always #2 clk = ~clk;

  //////////////////////////////
  // spi host side

  // msb first, 4 clk per sck half period, miso taken just before sck rises
  task automatic shift_frame(input logic [15:0] word, input int nbits,
                             output logic [15:0] rx);
    rx = '0;
    cs_n = 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      mosi = word[15-i];
      repeat (4) @(negedge clk);
      rx[15-i] = miso;
      sck = 1'b1;
      repeat (4) @(negedge clk);
      sck = 1'b0;
    end
    repeat (4) @(negedge clk);
    cs_n = 1'b1;
    mosi = 1'b0;
    // bank updates 4 cycles after cs_n rises
    repeat (8) @(negedge clk);
  endtask

  task automatic spi_frame(input smu_ctrl_pkg::spi_byte_t addr,
                           input smu_ctrl_pkg::spi_byte_t val, output logic [15:0] rx);
    shift_frame({addr, val}, 16, rx);
  endtask

  // cut short after 12 bits, must be dropped
  task automatic spi_short_frame(input logic [15:0] word);
    logic [15:0] rx;
    shift_frame(word, 12, rx);
  endtask

  function automatic smu_ctrl_pkg::ctrl_nibble_t rand_nibble();
    logic [31:0] r;
    r = $random(seed);
    return r[3:0];
  endfunction

  // set/clear rule, overlapping bits flip
  function automatic smu_ctrl_pkg::ctrl_nibble_t expected_update(
    input smu_ctrl_pkg::ctrl_nibble_t old, input smu_ctrl_pkg::ctrl_nibble_t set_m,
    input smu_ctrl_pkg::ctrl_nibble_t clr_m);
    smu_ctrl_pkg::ctrl_nibble_t both;
    both = set_m & clr_m;
    if (both != '0)
      return old ^ both;
    return (old | set_m) & ~clr_m;
  endfunction

  task automatic write_reg(input int slot, input smu_ctrl_pkg::ctrl_nibble_t set_m,
                           input smu_ctrl_pkg::ctrl_nibble_t clr_m);
    logic [15:0] rx;
    spi_frame(smu_ctrl_pkg::spi_byte_t'(smu_ctrl_pkg::REG_BASE + slot), {clr_m, set_m}, rx);
    exp_bank[slot] = expected_update(exp_bank[slot], set_m, clr_m);
  endtask

  //////////////////////////////
  // compare tasks

  task automatic check_bank(input smu_ctrl_pkg::ctrl_bank_t got, exp, input string what);
    if (got !== exp)
    begin
      $display("mismatch at time %0t: %s, got %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_nibble(input smu_ctrl_pkg::ctrl_nibble_t got, exp, input string what);
    if (got !== exp)
    begin
      $display("mismatch at time %0t: %s, got %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_byte(input smu_ctrl_pkg::spi_byte_t got, exp, input string what);
    if (got !== exp)
    begin
      $display("mismatch at time %0t: %s, got %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input logic got, exp, input string what);
    if (got !== exp)
    begin
      $display("mismatch at time %0t: %s, got %b expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("test %s: %s", name, (err_cnt == last_err) ? "ok" : "failed");
    last_err = err_cnt;
  endtask

  //////////////////////////////
  // tests

  task automatic test_reset();
    check_bank(reg_out, smu_ctrl_pkg::SOFT_RESET_VAL, "reg_out after reset");
    check_nibble(periph_cs_n, 4'hF, "periph_cs_n after reset");
    check_bit(miso, 1'b1, "miso after reset");
    finish_test("reset values");
  endtask

  task automatic test_set_clear();
    smu_ctrl_pkg::ctrl_nibble_t set_m;
    smu_ctrl_pkg::ctrl_nibble_t clr_m;
    for (int i = 0; i < NUM_REGS; i++)
    begin
      // random old value first, then a disjoint pair
      set_m = rand_nibble();
      write_reg(i, set_m, ~set_m);
      check_bank(reg_out, exp_bank, "bank after loading old value");
      set_m = rand_nibble();
      clr_m = rand_nibble() & ~set_m;
      write_reg(i, set_m, clr_m);
      check_bank(reg_out, exp_bank, "bank after set/clear write");
    end
    finish_test("set/clear writes");
  endtask

  task automatic test_toggle();
    smu_ctrl_pkg::ctrl_nibble_t ov;
    logic [15:0] rx;
    for (int k = 0; k < 4; k++)
    begin
      // at least one bit in both nibbles
      ov = rand_nibble() | (4'b0001 << k);
      write_reg(k, ov | rand_nibble(), ov | rand_nibble());
      check_bank(reg_out, exp_bank, "bank after toggle write");
    end
    // the receive shifter keeps the tail of the previous frame
    // end a frame to an unused address with the top nibble of REG_BASE
    spi_frame(8'd31, {4'h0, smu_ctrl_pkg::REG_BASE[7:4]}, rx);
    // with that tail in front the 12 bits spell a write inverting slot 0
    spi_short_frame({smu_ctrl_pkg::REG_BASE[3:0], exp_bank[0], ~exp_bank[0], 4'h0});
    check_bank(reg_out, exp_bank, "bank after 12-bit frame");
    finish_test("toggle");
  endtask

  task automatic test_presets();
    smu_ctrl_pkg::ctrl_nibble_t v;
    logic [15:0] rx;
    for (int i = 0; i < NUM_REGS; i++)
    begin
      if (smu_ctrl_pkg::RAILS_UP_KEEP[i])
      begin
        // nonzero, so a kept slot differs from its preset entry
        v = rand_nibble() | 4'b0001;
        write_reg(i, v, ~v);
      end
    end
    spi_frame(smu_ctrl_pkg::ADDR_RAILS_UP, 8'h00, rx);
    for (int i = 0; i < NUM_REGS; i++)
    begin
      if (!smu_ctrl_pkg::RAILS_UP_KEEP[i])
        exp_bank[i] = smu_ctrl_pkg::RAILS_UP_VAL[i];
    end
    check_bank(reg_out, exp_bank, "bank after rails-up");
    spi_frame(smu_ctrl_pkg::ADDR_SOFT_RESET, 8'h00, rx);
    exp_bank = smu_ctrl_pkg::SOFT_RESET_VAL;
    check_bank(reg_out, exp_bank, "bank after soft reset");
    finish_test("presets");
  endtask

  task automatic test_readback();
    smu_ctrl_pkg::ctrl_nibble_t v;
    logic [15:0] rx;
    for (int i = 0; i < NUM_REGS; i++)
    begin
      v = rand_nibble();
      write_reg(i, v, ~v);
      // value byte of zero leaves the slot as it is
      spi_frame(smu_ctrl_pkg::spi_byte_t'(smu_ctrl_pkg::REG_BASE + i), 8'h00, rx);
      check_byte(rx[15:8], 8'hFF, "idle byte during address");
      check_byte(rx[7:0], {4'h0, exp_bank[i]}, "slot readback");
    end
    // nonzero, tells the monitor apart from an unused address
    mon_rails = rand_nibble() | 4'b1000;
    spi_frame(smu_ctrl_pkg::ADDR_MON_RAILS, 8'h00, rx);
    check_byte(rx[7:0], {4'h0, mon_rails}, "mon_rails readback");
    spi_frame(8'd31, 8'h00, rx);
    check_byte(rx[7:0], 8'h00, "unused address readback");
    finish_test("readback");
  endtask

  task automatic test_passthru();
    smu_ctrl_pkg::ctrl_nibble_t sel;
    smu_ctrl_pkg::ctrl_nibble_t pm;
    sel = rand_nibble() | 4'b0100;
    write_reg(smu_ctrl_pkg::SLOT_PERIPH_SEL, sel, ~sel);
    cs2_n = 1'b0;
    for (int k = 0; k < 6; k++)
    begin
      pm = rand_nibble();
      periph_miso = pm;
      @(negedge clk);
      check_nibble(periph_cs_n, ~sel, "periph_cs_n with cs2_n low");
      check_bit(miso, |(sel & pm), "miso from selected peripherals");
    end
    cs2_n = 1'b1;
    @(negedge clk);
    check_nibble(periph_cs_n, 4'hF, "periph_cs_n with cs2_n high");
    check_bit(miso, 1'b1, "miso back on idle receiver");
    finish_test("peripheral pass-through");
  endtask

  //////////////////////////////
  // main sequence and watchdog

  initial
  begin
    arst_n = 1'b0;
    sck = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    cs2_n = 1'b1;
    mon_rails = '0;
    periph_miso = '0;
    exp_bank = smu_ctrl_pkg::SOFT_RESET_VAL;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    test_reset();
    test_set_clear();
    test_toggle();
    test_presets();
    test_readback();
    test_passthru();
    if (DUT.u_assert.fail_cnt != 0)
    begin
      $display("%0d assertion failures in the bound checker", DUT.u_assert.fail_cnt);
      err_cnt += DUT.u_assert.fail_cnt;
    end
    $display("tests run %0d, errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d clk cycles", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== smu_ctrl_top.f ====
hdl/smu_ctrl_pkg.sv
hdl/reg_bus_if.sv
hdl/spi_frame_rx.sv
hdl/ctrl_reg_slot.sv
hdl/readback_sel.sv
hdl/periph_spi_mux.sv
hdl/smu_ctrl_top.sv
test/smu_ctrl_assert.sv
test/smu_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: smu_ctrl

sources:
  - hdl/smu_ctrl_pkg.sv
  - hdl/reg_bus_if.sv
  - hdl/spi_frame_rx.sv
  - hdl/ctrl_reg_slot.sv
  - hdl/readback_sel.sv
  - hdl/periph_spi_mux.sv
  - hdl/smu_ctrl_top.sv
  - target: test
    files:
      - test/smu_ctrl_assert.sv
      - test/smu_ctrl_tb.sv
